// File: src.f
+incdir+design
design/beeb_pkg.sv
design/beeb_rom_bank.sv
design/beeb_main_ram.sv
design/beeb_mouse_axis.sv
design/beeb_board_top.sv
bench/beeb_board_checker.sv
bench/beeb_board_tb.sv

// File: Makefile
TOP := beeb_board_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o $(TOP)
	out=$$(./obj_dir/$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// File: bench/beeb_board_tb.sv
//////////////////////////////
// testbench for the beeb board glue
// rom load and map, apb errors, ram, mouse
//////////////////////////////
`timescale 1ns/1ps
`include "beeb_defs.svh"

module beeb_board_tb;

	localparam int CLK_PERIOD    = 20;
	localparam int SLOT_BYTES    = 4;
	localparam int RAM_BYTES     = 8;
	localparam int WE_HOLD       = 3;
	localparam int BIG_PKTS      = 14;
	// reset, load, two maps, errors, ram, mouse
	localparam int TEST_CYCLES   = 10 + `BEEB_ROM_SLOTS * SLOT_BYTES * 3
		+ 2 * (16 * SLOT_BYTES * 2 + 4) + 3 * 8
		+ RAM_BYTES * (WE_HOLD + 4) + (BIG_PKTS + 8) * 2 + 8;
	localparam int MARGIN_CYCLES = 200;
	localparam logic [17:0] RAM_BASE = 18'h02a00;

	logic                clk_sys;
	logic                rst_n;
	beeb_pkg::cpu_addr_u mem_addr;
	logic                mem_we_n;
	logic [7:0]          mem_wdata;
	logic [7:0]          mem_rdata;
	logic                model_sel;
	logic                reset_req;
	logic                load_hold;
	logic                psel;
	logic                penable;
	logic                pwrite;
	logic [17:0]         paddr;
	logic [7:0]          pwdata;
	logic                pready;
	logic                pslverr;
	logic [24:0]         mouse_pkt;
	logic [7:0]          joy_x;
	logic [7:0]          joy_y;
	logic [15:0]         joy_buttons;
	logic                mouse_disable;
	logic [11:0]         axis_x;
	logic [11:0]         axis_y;
	logic                axis_fire_n;

	logic [31:0] lfsr;
	int          err_cnt;
	int          chk_cnt;
	// expected rom bytes per slot, ram bytes per index
	logic [7:0]  rom_exp [`BEEB_ROM_SLOTS][SLOT_BYTES];
	logic [7:0]  ram_exp [RAM_BYTES];
	// reference mouse position and packet strobe
	logic        strobe;
	int          pos_x;
	int          pos_y;

	beeb_board_top u_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		chk_cnt++;
		assert (act === exp) else begin
			$display("Fail %s: expected %0h, actual %0h", name, exp, act);
			err_cnt++;
		end
	endtask

	// setup, access, idle; response checked mid access phase
	task automatic apb_xfer(input logic wr, input logic [17:0] addr, input logic [7:0] data,
		input logic exp_err);
		@(negedge clk_sys);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk_sys);
		penable = 1'b1;
		@(posedge clk_sys);
		expect_eq("apb pready", 1, pready);
		expect_eq("apb pslverr", exp_err, pslverr);
		@(negedge clk_sys);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic latch_model(input logic master);
		@(negedge clk_sys);
		model_sel = master;
		reset_req = 1'b1;
		@(negedge clk_sys);
		reset_req = 1'b0;
	endtask

	// data valid one clock after the address
	task automatic cpu_read(input logic [18:0] addr, output logic [7:0] data);
		@(negedge clk_sys);
		mem_addr = addr;
		@(negedge clk_sys);
		data = mem_rdata;
	endtask

	// bank to slot as listed for each model, -1 for unused
	function automatic int slot_of(input logic master, input int bank);
		if (!master) begin
			case (bank)
				4:       return 0;
				8:       return 1;
				14:      return 2;
				15:      return 3;
				default: return -1;
			endcase
		end
		case (bank)
			2, 3:              return bank + 2;
			4:                 return 6;
			9, 10, 11:         return bank - 2;
			12, 13, 14, 15:    return bank - 2;
			default:           return -1;
		endcase
	endfunction

	task automatic check_map(input logic master, input string name);
		logic [7:0] d;
		int         s;
		for (int bank = 0; bank < 16; bank++) begin
			for (int k = 0; k < SLOT_BYTES; k++) begin
				cpu_read({1'b0, 4'(bank), 14'(k)}, d);
				s = slot_of(master, bank);
				expect_eq(name, (s < 0) ? 8'h00 : rom_exp[s][k], d);
			end
		end
	endtask

	// one falling edge, then garbage on the lower neighbor while held low
	task automatic ram_write(input logic [17:0] addr, input logic [7:0] data);
		@(negedge clk_sys);
		mem_addr  = {1'b1, addr};
		mem_wdata = data;
		mem_we_n  = 1'b0;
		repeat (WE_HOLD) begin
			@(negedge clk_sys);
			mem_addr  = {1'b1, addr - 18'd1};
			mem_wdata = ~data;
		end
		@(negedge clk_sys);
		mem_we_n = 1'b1;
	endtask

	function automatic int clamp_int(input int v, input int lo, input int hi);
		return (v < lo) ? lo : ((v > hi) ? hi : v);
	endfunction

	// signed position to inverted offset binary, top nibble repeated
	function automatic logic [11:0] axis_exp(input int p);
		logic [7:0] val;
		val = 8'(127 - p);
		return {val, val[7:4]};
	endfunction

	// sign bit plus 7 movement bits per axis
	function automatic logic [24:0] make_pkt(input logic stb, input int dx, input int dy,
		input logic [1:0] btn);
		logic [24:0] pkt;
		logic [8:0]  x9;
		logic [8:0]  y9;
		x9 = 9'(dx);
		y9 = 9'(dy);
		pkt          = '0;
		pkt[24]      = stb;
		pkt[23:17]   = y9[6:0];
		pkt[15:9]    = x9[6:0];
		pkt[5]       = (dy < 0);
		pkt[4]       = (dx < 0);
		pkt[1:0]     = btn;
		return pkt;
	endfunction

	task automatic send_pkt(input int dx, input int dy, input logic [1:0] btn);
		strobe = ~strobe;
		@(negedge clk_sys);
		mouse_pkt = make_pkt(strobe, dx, dy, btn);
		pos_x = clamp_int(pos_x + clamp_int(dx, -`BEEB_MOUSE_STEP, `BEEB_MOUSE_STEP),
			`BEEB_AXIS_MIN, `BEEB_AXIS_MAX);
		pos_y = clamp_int(pos_y - clamp_int(dy, -`BEEB_MOUSE_STEP, `BEEB_MOUSE_STEP),
			`BEEB_AXIS_MIN, `BEEB_AXIS_MAX);
		@(negedge clk_sys);
		expect_eq("mouse x", axis_exp(pos_x), axis_x);
		expect_eq("mouse y", axis_exp(pos_y), axis_y);
		// released only with no button pressed
		expect_eq("mouse fire", (btn == 2'b00), axis_fire_n);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		logic [31:0] r;
		logic [7:0]  d;
		rst_n = 1'b0;
		mem_addr = '0;
		mem_we_n = 1'b1;
		mem_wdata = '0;
		model_sel = 1'b0;
		reset_req = 1'b0;
		load_hold = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		mouse_pkt = '0;
		joy_x = '0;
		joy_y = '0;
		joy_buttons = '0;
		mouse_disable = 1'b0;
		lfsr = 32'h3e9f;
		err_cnt = 0;
		chk_cnt = 0;
		strobe = 1'b0;
		pos_x = 0;
		pos_y = 0;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;

		// rom image load, then master map
		load_hold = 1'b1;
		for (int s = 0; s < `BEEB_ROM_SLOTS; s++) begin
			for (int k = 0; k < SLOT_BYTES; k++) begin
				r = next_bits(8);
				rom_exp[s][k] = r[7:0];
				apb_xfer(1'b1, 18'(s * (1 << `BEEB_OFFSET_W) + k), r[7:0], 1'b0);
			end
		end
		load_hold = 1'b0;
		latch_model(1'b1);
		check_map(1'b1, "master map");

		// model b, misses read zero
		latch_model(1'b0);
		check_map(1'b0, "model b map");

		// refused apb accesses leave the image alone
		apb_xfer(1'b1, 18'd0, ~rom_exp[0][0], 1'b1);
		cpu_read({1'b0, 4'd4, 14'd0}, d);
		expect_eq("apb write unloaded", rom_exp[0][0], d);
		load_hold = 1'b1;
		apb_xfer(1'b1, 18'(`BEEB_ROM_WORDS), 8'h5a, 1'b1);
		apb_xfer(1'b0, 18'd1, 8'ha5, 1'b1);
		load_hold = 1'b0;
		cpu_read({1'b0, 4'd4, 14'd1}, d);
		expect_eq("apb read", rom_exp[0][1], d);

		// ram bytes, one write per we_n fall
		for (int i = 0; i < RAM_BYTES; i++) begin
			r = next_bits(8);
			ram_exp[i] = r[7:0];
			ram_write(RAM_BASE + 18'(i), r[7:0]);
		end
		for (int i = 0; i < RAM_BYTES; i++) begin
			cpu_read({1'b1, RAM_BASE + 18'(i)}, d);
			expect_eq("ram read", ram_exp[i], d);
		end

		// mouse steps, clamp and saturation
		r = next_bits(16);
		joy_x = r[7:0];
		joy_y = r[15:8];
		send_pkt(50, 50, 2'b00);
		send_pkt(-3, -3, 2'b00);
		repeat (BIG_PKTS) send_pkt(100, 100, 2'b00);
		repeat (2) send_pkt(-100, -100, 2'b00);

		// joystick button takes the axis back
		@(negedge clk_sys);
		joy_buttons = 16'h0001;
		pos_x = 0;
		pos_y = 0;
		@(negedge clk_sys);
		expect_eq("joy x", axis_exp($signed(joy_x)), axis_x);
		expect_eq("joy y", axis_exp($signed(joy_y)), axis_y);
		expect_eq("joy fire off", 1, axis_fire_n);
		joy_buttons = 16'h0010;
		@(negedge clk_sys);
		expect_eq("joy fire on", 0, axis_fire_n);
		joy_buttons = 16'h0000;

		// fire from the mouse buttons in emulation
		send_pkt(2, -1, 2'b10);
		send_pkt(0, 0, 2'b01);
		send_pkt(0, 0, 2'b00);

		$display("checks %0d, errors %0d, checker errors %0d",
			chk_cnt, err_cnt, u_dut.u_checker.fail_cnt);
		if (err_cnt == 0 && u_dut.u_checker.fail_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
		$display("timeout: stimulus did not finish within %0d cycles",
			TEST_CYCLES + MARGIN_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule

// File: bench/beeb_board_checker.sv
//////////////////////////////
// concurrent checks on the board top
//////////////////////////////
`timescale 1ns/1ps

module beeb_board_checker (
	input logic clk_sys,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic mem_we_n,
	input logic ram_wr,
	input logic axis_fire_n
);

	// failed assertions so far
	int unsigned fail_cnt = 0;

	// zero wait states
	apb_ready_a: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(psel && penable) |-> pready)
	else begin
		$error("pready low in an apb access phase");
		fail_cnt++;
	end

	// a write needs we_n high the clock before
	ram_edge_a: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ram_wr |-> $past(mem_we_n))
	else begin
		$error("ram write without a falling write enable");
		fail_cnt++;
	end

	// fire released when reset ends
	fire_reset_a: assert property (@(posedge clk_sys)
		$rose(rst_n) |-> axis_fire_n)
	else begin
		$error("axis_fire_n low after reset");
		fail_cnt++;
	end

	apb_err_a: assert property (@(posedge clk_sys) disable iff (!rst_n)
		pslverr |-> (psel && penable))
	else begin
		$error("pslverr outside an apb access phase");
		fail_cnt++;
	end

endmodule

bind beeb_board_top beeb_board_checker u_checker (
	.clk_sys     (clk_sys),
	.rst_n       (rst_n),
	.psel        (psel),
	.penable     (penable),
	.pready      (pready),
	.pslverr     (pslverr),
	.mem_we_n    (mem_we_n),
	.ram_wr      (u_main_ram.wr_en),
	.axis_fire_n (axis_fire_n)
);

// File: design/beeb_board_top.sv
//////////////////////////////
// beeb board memory and input glue
//////////////////////////////
`timescale 1ns/1ps

module beeb_board_top (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	// cpu external bus
	input  beeb_pkg::cpu_addr_u  mem_addr,
	input  logic                 mem_we_n,
	input  logic [7:0]           mem_wdata,
	output logic [7:0]           mem_rdata,
	input  logic                 model_sel,
	input  logic                 reset_req,
	input  logic                 load_hold,
	// apb rom loader
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [17:0]          paddr,
	input  logic [7:0]           pwdata,
	output logic                 pready,
	output logic                 pslverr,
	// mouse and joystick
	input  logic [24:0]          mouse_pkt,
	input  logic [7:0]           joy_x,
	input  logic [7:0]           joy_y,
	input  logic [15:0]          joy_buttons,
	input  logic                 mouse_disable,
	output logic [11:0]          axis_x,
	output logic [11:0]          axis_y,
	output logic                 axis_fire_n
);

	logic [7:0] rom_rdata;
	logic [7:0] ram_rdata;
	// region of the address the memories latched
	logic       region_q;

	beeb_rom_bank u_rom_bank (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.mem_addr  (mem_addr),
		.model_sel (model_sel),
		.reset_req (reset_req),
		.load_hold (load_hold),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.rom_rdata (rom_rdata)
	);

	beeb_main_ram u_main_ram (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.mem_addr  (mem_addr),
		.mem_we_n  (mem_we_n),
		.mem_wdata (mem_wdata),
		.ram_rdata (ram_rdata)
	);

	beeb_mouse_axis u_mouse_axis (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.mouse_pkt     (mouse_pkt),
		.joy_x         (joy_x),
		.joy_y         (joy_y),
		.joy_buttons   (joy_buttons),
		.reset_req     (reset_req),
		.mouse_disable (mouse_disable),
		.axis_x        (axis_x),
		.axis_y        (axis_y),
		.axis_fire_n   (axis_fire_n)
	);

	// bit 18 of the previous address
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			region_q <= 1'b0;
		end else begin
			region_q <= mem_addr.ram_v.ram;
		end
	end

	// read data lines up with the memory latency
	assign mem_rdata = region_q ? ram_rdata : rom_rdata;

endmodule

// File: design/beeb_mouse_axis.sv
//////////////////////////////
// mouse to analog joystick
// clamped position, fire, joystick hand-off
//////////////////////////////
`timescale 1ns/1ps
`include "beeb_defs.svh"

module beeb_mouse_axis (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic [24:0] mouse_pkt,
	input  logic [7:0]  joy_x,
	input  logic [7:0]  joy_y,
	input  logic [15:0] joy_buttons,
	input  logic        reset_req,
	input  logic        mouse_disable,
	output logic [11:0] axis_x,
	output logic [11:0] axis_y,
	output logic        axis_fire_n
);

	// saturate to [lo, hi]
	function automatic logic signed [8:0] clamp9(
		input logic signed [8:0] v,
		input int                lo,
		input int                hi
	);
		if (v < lo) begin
			return 9'(lo);
		end
		if (v > hi) begin
			return 9'(hi);
		end
		return v;
	endfunction

	// offset binary, inverted, widened by the top nibble
	function automatic logic [11:0] to_axis(input logic [7:0] src);
		logic [7:0] ofs;
		logic [7:0] val;
		ofs = {~src[7], src[6:0]};
		val = 8'hff - ofs;
		return {val, val[7:4]};
	endfunction

	logic               emu_mode;
	logic               stb_q;
	logic signed [8:0]  pos_x;
	logic signed [8:0]  pos_y;
	logic signed [8:0]  dx;
	logic signed [8:0]  dy;
	logic signed [8:0]  dx_c;
	logic signed [8:0]  dy_c;
	logic signed [8:0]  nx;
	logic signed [8:0]  ny;
	logic               pkt_new;
	logic               hand_off;
	logic [7:0]         src_x;
	logic [7:0]         src_y;

	//////////////////////////////
	// packet deltas
	//////////////////////////////

	// sign doubled over the upper 7 movement bits
	assign dx   = {mouse_pkt[4], mouse_pkt[4], mouse_pkt[15:9]};
	assign dy   = {mouse_pkt[5], mouse_pkt[5], mouse_pkt[23:17]};
	assign dx_c = clamp9(dx, -`BEEB_MOUSE_STEP, `BEEB_MOUSE_STEP);
	assign dy_c = clamp9(dy, -`BEEB_MOUSE_STEP, `BEEB_MOUSE_STEP);

	// y runs opposite to the mouse
	assign nx = pos_x + dx_c;
	assign ny = pos_y - dy_c;

	// toggle strobe marks a fresh packet
	assign pkt_new  = mouse_pkt[24] ^ stb_q;
	// real joystick or reset takes the axis back
	assign hand_off = (|joy_buttons) | reset_req | mouse_disable;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			stb_q    <= 1'b0;
			emu_mode <= 1'b0;
			pos_x    <= '0;
			pos_y    <= '0;
		end else begin
			stb_q <= mouse_pkt[24];
			if (hand_off) begin
				emu_mode <= 1'b0;
				pos_x    <= '0;
				pos_y    <= '0;
			end else if (pkt_new) begin
				emu_mode <= 1'b1;
				pos_x    <= clamp9(nx, `BEEB_AXIS_MIN, `BEEB_AXIS_MAX);
				pos_y    <= clamp9(ny, `BEEB_AXIS_MIN, `BEEB_AXIS_MAX);
			end
		end
	end

	//////////////////////////////
	// outputs
	//////////////////////////////

	assign src_x = emu_mode ? pos_x[7:0] : joy_x;
	assign src_y = emu_mode ? pos_y[7:0] : joy_y;

	assign axis_x = to_axis(src_x);
	assign axis_y = to_axis(src_y);

	// active low, either mouse button in emulation
	assign axis_fire_n = ~(emu_mode ? |mouse_pkt[1:0] : joy_buttons[4]);

endmodule

// File: design/beeb_main_ram.sv
//////////////////////////////
// main ram, one write per we_n fall
//////////////////////////////
`timescale 1ns/1ps
`include "beeb_defs.svh"

module beeb_main_ram (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  beeb_pkg::cpu_addr_u  mem_addr,
	input  logic                 mem_we_n,
	input  logic [7:0]           mem_wdata,
	output logic [7:0]           ram_rdata
);

	// we_n from the previous clock
	logic        we_n_q;
	logic        wr_en;
	logic [17:0] addr_q;
	logic [7:0]  ram_mem [`BEEB_RAM_WORDS];

	// idle high so a low at reset exit counts as an edge
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			we_n_q <= 1'b1;
		end else begin
			we_n_q <= mem_we_n;
		end
	end

	// first low clock after high, ram region only
	assign wr_en = mem_addr.ram_v.ram & we_n_q & ~mem_we_n;

	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			ram_mem[mem_addr.ram_v.addr] <= mem_wdata;
		end
		// registered read address
		addr_q <= mem_addr.ram_v.addr;
	end

	// data one clock after the address
	assign ram_rdata = ram_mem[addr_q];

endmodule

// File: design/beeb_rom_bank.sv
//////////////////////////////
// rom bank translation and storage
// model latch, bank map, apb image loader
//////////////////////////////
`timescale 1ns/1ps
`include "beeb_defs.svh"

module beeb_rom_bank (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  beeb_pkg::cpu_addr_u  mem_addr,
	input  logic                 model_sel,
	input  logic                 reset_req,
	input  logic                 load_hold,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [17:0]          paddr,
	input  logic [7:0]           pwdata,
	output logic                 pready,
	output logic                 pslverr,
	output logic [7:0]           rom_rdata
);

	// high selects the master 128 map
	logic                master;
	beeb_pkg::rom_slot_t slot;
	logic                hit;
	logic                apb_access;
	logic                apb_wr;
	logic [17:0]         port_addr;
	logic [17:0]         addr_q;
	logic                hit_q;
	logic [7:0]          rom_mem [`BEEB_ROM_WORDS];

	//////////////////////////////
	// model latch
	//////////////////////////////

	// sampled while the core asks for reset
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			master <= 1'b0;
		end else if (reset_req) begin
			master <= model_sel;
		end
	end

	//////////////////////////////
	// bank map
	//////////////////////////////

	// {model, bank} to dense slot
	always_comb begin
		slot = '0;
		hit  = 1'b1;
		case ({master, mem_addr.rom_v.bank})
			// model b: os, mmfs, ram master, basic
			5'b0_0100: slot = 4'd0;
			5'b0_1000: slot = 4'd1;
			5'b0_1110: slot = 4'd2;
			5'b0_1111: slot = 4'd3;
			// master: adfs and mmfs low
			5'b1_0010: slot = 4'd4;
			5'b1_0011: slot = 4'd5;
			// mos
			5'b1_0100: slot = 4'd6;
			// dfs, viewsheet, edit
			5'b1_1001: slot = 4'd7;
			5'b1_1010: slot = 4'd8;
			5'b1_1011: slot = 4'd9;
			// basic4, adfs, view, terminal
			5'b1_1100: slot = 4'd10;
			5'b1_1101: slot = 4'd11;
			5'b1_1110: slot = 4'd12;
			5'b1_1111: slot = 4'd13;
			// unused bank, reads as zero
			default:   hit = 1'b0;
		endcase
	end

	//////////////////////////////
	// apb loader
	//////////////////////////////

	// zero wait states, every access phase completes
	assign apb_access = psel & penable;
	assign pready     = apb_access;

	// legal only in load mode and inside the image
	assign apb_wr  = apb_access & pwrite & load_hold & (paddr < `BEEB_ROM_WORDS);
	// reads and illegal writes are refused
	assign pslverr = apb_access & ~apb_wr;

	// loader owns the port while held
	assign port_addr = load_hold ? paddr : {slot, mem_addr.rom_v.offset};

	always_ff @(posedge clk_sys) begin
		if (apb_wr) begin
			rom_mem[paddr] <= pwdata;
		end
		addr_q <= port_addr;
	end

	// hit travels with the registered address
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			hit_q <= 1'b0;
		end else begin
			hit_q <= hit;
		end
	end

	// one clock after the address, misses give 0
	assign rom_rdata = hit_q ? rom_mem[addr_q] : 8'h00;

endmodule

// File: design/beeb_pkg.sv
//////////////////////////////
// shared types for the beeb memory glue
//////////////////////////////
`include "beeb_defs.svh"

package beeb_pkg;

	// ram view of a cpu address
	// region flag high, then the ram byte address
	typedef struct packed {
		logic                      ram;
		logic [`BEEB_ADDR_W-2:0]   addr;
	} cpu_ram_view_t;

	// rom view of the same word
	// region flag low, bank number, offset in bank
	typedef struct packed {
		logic                      ram;
		logic [`BEEB_BANK_W-1:0]   bank;
		logic [`BEEB_OFFSET_W-1:0] offset;
	} cpu_rom_view_t;

	// one cpu address, decoded either way
	typedef union packed {
		cpu_ram_view_t ram_v;
		cpu_rom_view_t rom_v;
	} cpu_addr_u;

	// slot index into the dense rom image
	typedef logic [`BEEB_BANK_W-1:0] rom_slot_t;

endpackage

// File: design/beeb_defs.svh
//////////////////////////////
// board constants for the beeb memory glue
// widths, memory sizes and mouse limits
//////////////////////////////
`ifndef BEEB_DEFS_SVH
`define BEEB_DEFS_SVH

// cpu external address, bit 18 picks ram
`define BEEB_ADDR_W 19
// byte offset inside one 16K bank
`define BEEB_OFFSET_W 14
// bank number field above the offset
`define BEEB_BANK_W 4

// dense rom image, only filled slots kept
`define BEEB_ROM_SLOTS 14
// 14 slots of 16K each
`define BEEB_ROM_WORDS (`BEEB_ROM_SLOTS * (1 << `BEEB_OFFSET_W))
// main ram bytes
`define BEEB_RAM_WORDS 212992

// largest mouse delta taken per packet
`define BEEB_MOUSE_STEP 10
// clamp range of the emulated axis
`define BEEB_AXIS_MIN (-128)
`define BEEB_AXIS_MAX 127

`endif
